// File: rtl/video_pkg.sv
package video_pkg;

    ////////////////////
    // frame geometry
    ////////////////////

    // raw sensor frame, reduced size
    localparam int RAW_WIDTH  = 16;
    localparam int RAW_HEIGHT = 12;

    // crop window
    localparam int ROI_WIDTH  = 8;
    localparam int ROI_HEIGHT = 8;

    // after 2x2 binning
    localparam int BIN_WIDTH  = 4;
    localparam int BIN_HEIGHT = 4;

    localparam int PIX_BITS     = 8;
    localparam int COORD_BITS   = 8;
    localparam int FRAME_PIXELS = BIN_WIDTH * BIN_HEIGHT;

    ////////////////////
    // host framing
    ////////////////////

    // "BIVFRAME", first byte in the top bits
    localparam logic [63:0] MAGIC_NUM   = 64'h4249_5646_5241_4D45;
    localparam int          MAGIC_BYTES = 8;

    // room for two binned frames
    localparam int FIFO_DEPTH = 2 * FRAME_PIXELS;

    typedef enum logic [1:0] {
        PK_IDLE,
        PK_HEADER,
        PK_PIXELS
    } packer_state_e;

endpackage

// File: rtl/host_pkg.sv
package host_pkg;

    // command is addr then data, both msb first
    localparam int CMD_BYTES     = 6;
    localparam int CMD_ADDR_BITS = 16;
    localparam int CMD_DATA_BITS = 32;

    // register map, everything else is ignored
    typedef enum logic [15:0] {
        REG_ROI_COL = 16'd0,
        REG_ROI_ROW = 16'd1
    } reg_addr_e;

    // centres the 8x8 crop in the 16x12 frame
    localparam int ROI_COL_RESET = 4;
    localparam int ROI_ROW_RESET = 2;

endpackage

// File: rtl/roi_crop.sv
module roi_crop (
    input  logic                             core_clk,
    input  logic                             sys_reset,
    input  logic                             pix_valid_i,
    input  logic                             pix_sof_i,
    input  logic [video_pkg::PIX_BITS-1:0]   pix_data_i,
    input  logic [video_pkg::COORD_BITS-1:0] roi_col_i,
    input  logic [video_pkg::COORD_BITS-1:0] roi_row_i,
    output logic                             crop_valid_o,
    output logic                             crop_sof_o,
    output logic [video_pkg::PIX_BITS-1:0]   crop_data_o,
    output logic                             crop_odd_row_o,
    output logic                             crop_odd_col_o
);

    // raw position of the next expected pixel
    logic [video_pkg::COORD_BITS-1:0] col_q;
    logic [video_pkg::COORD_BITS-1:0] row_q;
    // corner in use for the current frame
    logic [video_pkg::COORD_BITS-1:0] win_col_q;
    logic [video_pkg::COORD_BITS-1:0] win_row_q;

    logic                             sof_pix;
    logic [video_pkg::COORD_BITS-1:0] cur_col;
    logic [video_pkg::COORD_BITS-1:0] cur_row;
    logic [video_pkg::COORD_BITS-1:0] cor_col;
    logic [video_pkg::COORD_BITS-1:0] cor_row;
    logic [video_pkg::COORD_BITS-1:0] rel_col;
    logic [video_pkg::COORD_BITS-1:0] rel_row;
    logic                             in_win;

    assign sof_pix = pix_valid_i && pix_sof_i;

    // start of frame forces position 0 and picks up the new corner at once
    assign cur_col = sof_pix ? '0 : col_q;
    assign cur_row = sof_pix ? '0 : row_q;
    assign cor_col = sof_pix ? roi_col_i : win_col_q;
    assign cor_row = sof_pix ? roi_row_i : win_row_q;

    assign rel_col = cur_col - cor_col;
    assign rel_row = cur_row - cor_row;

    assign in_win = (cur_col >= cor_col) && (cur_row >= cor_row)
                 && (rel_col < video_pkg::COORD_BITS'(video_pkg::ROI_WIDTH))
                 && (rel_row < video_pkg::COORD_BITS'(video_pkg::ROI_HEIGHT));

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q        <= '0;
            row_q        <= '0;
            win_col_q    <= '0;
            win_row_q    <= '0;
            crop_valid_o <= 1'b0;
            crop_sof_o   <= 1'b0;
        end else begin
            crop_valid_o <= pix_valid_i && in_win;
            crop_sof_o   <= pix_valid_i && in_win && (rel_col == '0) && (rel_row == '0);
            if (sof_pix) begin
                win_col_q <= roi_col_i;
                win_row_q <= roi_row_i;
            end
            // raster walk
            if (pix_valid_i) begin
                if (cur_col == video_pkg::COORD_BITS'(video_pkg::RAW_WIDTH - 1)) begin
                    col_q <= '0;
                    if (cur_row == video_pkg::COORD_BITS'(video_pkg::RAW_HEIGHT - 1)) begin
                        row_q <= '0;
                    end else begin
                        row_q <= cur_row + 1'b1;
                    end
                end else begin
                    col_q <= cur_col + 1'b1;
                    row_q <= cur_row;
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        crop_data_o    <= pix_data_i;
        crop_odd_row_o <= rel_row[0];
        crop_odd_col_o <= rel_col[0];
    end

endmodule

// File: rtl/pixel_binner.sv
module pixel_binner (
    input  logic                           core_clk,
    input  logic                           sys_reset,
    input  logic                           crop_valid_i,
    input  logic                           crop_sof_i,
    input  logic [video_pkg::PIX_BITS-1:0] crop_data_i,
    input  logic                           crop_odd_row_i,
    input  logic                           crop_odd_col_i,
    output logic                           bin_valid_o,
    output logic                           bin_sof_o,
    output logic [video_pkg::PIX_BITS-1:0] bin_data_o
);

    ////////////////////
    // storage
    ////////////////////

    // half-line of horizontal pair sums from the even row
    logic [video_pkg::PIX_BITS:0]   line_buf [video_pkg::BIN_WIDTH];
    logic [video_pkg::PIX_BITS-1:0] left_q;
    logic [$clog2(video_pkg::BIN_WIDTH)-1:0] pair_q;
    // start seen, block 0 not yet out
    logic                           sof_pend_q;

    logic [video_pkg::PIX_BITS:0]   pair_sum;
    logic [video_pkg::PIX_BITS+1:0] block_sum;
    logic                           pair_done;
    logic                           block_done;

    assign pair_done  = crop_valid_i && crop_odd_col_i;
    assign block_done = pair_done && crop_odd_row_i;

    assign pair_sum  = {1'b0, left_q} + {1'b0, crop_data_i};
    assign block_sum = {1'b0, line_buf[pair_q]} + {1'b0, pair_sum};

    ////////////////////
    // datapath
    ////////////////////

    always_ff @(posedge core_clk) begin
        if (crop_valid_i && !crop_odd_col_i) begin
            left_q <= crop_data_i;
        end
        if (pair_done && !crop_odd_row_i) begin
            line_buf[pair_q] <= pair_sum;
        end
        // divide by four, rounding down
        bin_data_o <= block_sum[video_pkg::PIX_BITS+1:2];
    end

    ////////////////////
    // control
    ////////////////////

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            pair_q      <= '0;
            sof_pend_q  <= 1'b0;
            bin_valid_o <= 1'b0;
            bin_sof_o   <= 1'b0;
        end else begin
            bin_valid_o <= block_done;
            bin_sof_o   <= block_done && sof_pend_q;

            if (crop_valid_i && crop_sof_i) begin
                pair_q     <= '0;
                sof_pend_q <= 1'b1;
            end else if (pair_done) begin
                if (pair_q == $bits(pair_q)'(video_pkg::BIN_WIDTH - 1)) begin
                    pair_q <= '0;
                end else begin
                    pair_q <= pair_q + 1'b1;
                end
            end

            if (block_done) begin
                sof_pend_q <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/stream_fifo.sv
module stream_fifo (
    input  logic                           core_clk,
    input  logic                           sys_reset,
    input  logic                           wr_en_i,
    input  logic                           wr_sof_i,
    input  logic [video_pkg::PIX_BITS-1:0] wr_data_i,
    input  logic                           rd_en_i,
    output logic                           rd_valid_o,
    output logic                           rd_sof_o,
    output logic [video_pkg::PIX_BITS-1:0] rd_data_o
);

    // each entry is {sof, pixel}
    logic [video_pkg::PIX_BITS:0] mem [video_pkg::FIFO_DEPTH];

    logic [$clog2(video_pkg::FIFO_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(video_pkg::FIFO_DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(video_pkg::FIFO_DEPTH):0]   count_q;
    logic                                     push;
    logic                                     pop;

    // full drops the write
    assign push = wr_en_i && (count_q != $bits(count_q)'(video_pkg::FIFO_DEPTH));
    assign pop  = rd_en_i && rd_valid_o;

    // show-ahead head entry
    assign rd_valid_o            = (count_q != '0);
    assign {rd_sof_o, rd_data_o} = mem[rd_ptr_q];

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr_q] <= {wr_sof_i, wr_data_i};
        end
    end

    // depth is a power of two so the pointers wrap on their own
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: rtl/frame_packer.sv
module frame_packer (
    input  logic                           core_clk,
    input  logic                           sys_reset,
    input  logic                           rd_valid_i,
    input  logic                           rd_sof_i,
    input  logic [video_pkg::PIX_BITS-1:0] rd_data_i,
    input  logic                           tx_stall_i,
    output logic                           rd_en_o,
    output logic                           tx_valid_o,
    output logic [video_pkg::PIX_BITS-1:0] tx_data_o
);

    video_pkg::packer_state_e state_q;
    // header byte index, then pixel index
    logic [$clog2(video_pkg::FRAME_PIXELS)-1:0] cnt_q;
    logic [$clog2(video_pkg::MAGIC_BYTES)-1:0]  hdr_idx;
    logic [video_pkg::PIX_BITS-1:0]             hdr_byte;

    // byte 0 is the top byte of the magic number
    assign hdr_idx  = $bits(hdr_idx)'(video_pkg::MAGIC_BYTES - 1) - cnt_q[$bits(hdr_idx)-1:0];
    assign hdr_byte = video_pkg::MAGIC_NUM[hdr_idx*8 +: 8];

    ////////////////////
    // outputs
    ////////////////////

    always_comb begin
        tx_valid_o = 1'b0;
        tx_data_o  = hdr_byte;
        rd_en_o    = 1'b0;
        case (state_q)
            // drop leftovers until a frame start sits at the head
            video_pkg::PK_IDLE: begin
                rd_en_o = rd_valid_i && !rd_sof_i;
            end
            video_pkg::PK_HEADER: begin
                tx_valid_o = !tx_stall_i;
            end
            video_pkg::PK_PIXELS: begin
                tx_valid_o = !tx_stall_i && rd_valid_i;
                tx_data_o  = rd_data_i;
                rd_en_o    = !tx_stall_i && rd_valid_i;
            end
            default: begin
                tx_valid_o = 1'b0;
            end
        endcase
    end

    ////////////////////
    // FSM
    ////////////////////

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q <= video_pkg::PK_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                video_pkg::PK_IDLE: begin
                    cnt_q <= '0;
                    if (rd_valid_i && rd_sof_i) begin
                        state_q <= video_pkg::PK_HEADER;
                    end
                end
                video_pkg::PK_HEADER: begin
                    if (tx_valid_o) begin
                        if (cnt_q == $bits(cnt_q)'(video_pkg::MAGIC_BYTES - 1)) begin
                            cnt_q   <= '0;
                            state_q <= video_pkg::PK_PIXELS;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                video_pkg::PK_PIXELS: begin
                    if (tx_valid_o) begin
                        if (cnt_q == $bits(cnt_q)'(video_pkg::FRAME_PIXELS - 1)) begin
                            cnt_q   <= '0;
                            state_q <= video_pkg::PK_IDLE;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= video_pkg::PK_IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/roi_command_regs.sv
module roi_command_regs (
    input  logic                             core_clk,
    input  logic                             sys_reset,
    input  logic                             host_valid_i,
    input  logic [7:0]                       host_data_i,
    output logic [video_pkg::COORD_BITS-1:0] roi_col_o,
    output logic [video_pkg::COORD_BITS-1:0] roi_row_o
);

    // {addr, data} once all six bytes are in
    logic [host_pkg::CMD_ADDR_BITS+host_pkg::CMD_DATA_BITS-1:0] cmd_q;
    logic [$clog2(host_pkg::CMD_BYTES)-1:0]                     byte_cnt_q;
    logic                                                       cmd_done_q;
    host_pkg::reg_addr_e                                        cmd_addr;

    assign cmd_addr = host_pkg::reg_addr_e'(cmd_q[$bits(cmd_q)-1 -: host_pkg::CMD_ADDR_BITS]);

    // bytes arrive msb first
    always_ff @(posedge core_clk) begin
        if (host_valid_i) begin
            cmd_q <= {cmd_q[$bits(cmd_q)-9:0], host_data_i};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt_q <= '0;
            cmd_done_q <= 1'b0;
            roi_col_o  <= video_pkg::COORD_BITS'(host_pkg::ROI_COL_RESET);
            roi_row_o  <= video_pkg::COORD_BITS'(host_pkg::ROI_ROW_RESET);
        end else begin
            cmd_done_q <= 1'b0;
            if (host_valid_i) begin
                if (byte_cnt_q == $bits(byte_cnt_q)'(host_pkg::CMD_BYTES - 1)) begin
                    byte_cnt_q <= '0;
                    cmd_done_q <= 1'b1;
                end else begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                end
            end

            // register write, one cycle after the last byte
            if (cmd_done_q) begin
                case (cmd_addr)
                    host_pkg::REG_ROI_COL: roi_col_o <= cmd_q[video_pkg::COORD_BITS-1:0];
                    host_pkg::REG_ROI_ROW: roi_row_o <= cmd_q[video_pkg::COORD_BITS-1:0];
                    default: begin
                        roi_col_o <= roi_col_o;
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/preview_top.sv
module preview_top (
    input  logic                           core_clk,
    input  logic                           sys_reset,
    input  logic                           pix_valid_i,
    input  logic                           pix_sof_i,
    input  logic [video_pkg::PIX_BITS-1:0] pix_data_i,
    input  logic                           host_valid_i,
    input  logic [7:0]                     host_data_i,
    input  logic                           tx_stall_i,
    output logic                           tx_valid_o,
    output logic [video_pkg::PIX_BITS-1:0] tx_data_o
);

    logic [video_pkg::COORD_BITS-1:0] roi_col_w;
    logic [video_pkg::COORD_BITS-1:0] roi_row_w;

    logic                           crop_valid_w;
    logic                           crop_sof_w;
    logic [video_pkg::PIX_BITS-1:0] crop_data_w;
    logic                           crop_odd_row_w;
    logic                           crop_odd_col_w;

    logic                           bin_valid_w;
    logic                           bin_sof_w;
    logic [video_pkg::PIX_BITS-1:0] bin_data_w;

    logic                           fifo_rd_en_w;
    logic                           fifo_valid_w;
    logic                           fifo_sof_w;
    logic [video_pkg::PIX_BITS-1:0] fifo_data_w;

    ////////////////////
    // host commands
    ////////////////////

    roi_command_regs cmd_regs0 (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .host_valid_i (host_valid_i),
        .host_data_i  (host_data_i),
        .roi_col_o    (roi_col_w),
        .roi_row_o    (roi_row_w)
    );

    ////////////////////
    // video pipeline
    ////////////////////

    roi_crop crop0 (
        .core_clk       (core_clk),
        .sys_reset      (sys_reset),
        .pix_valid_i    (pix_valid_i),
        .pix_sof_i      (pix_sof_i),
        .pix_data_i     (pix_data_i),
        .roi_col_i      (roi_col_w),
        .roi_row_i      (roi_row_w),
        .crop_valid_o   (crop_valid_w),
        .crop_sof_o     (crop_sof_w),
        .crop_data_o    (crop_data_w),
        .crop_odd_row_o (crop_odd_row_w),
        .crop_odd_col_o (crop_odd_col_w)
    );

    pixel_binner binner0 (
        .core_clk       (core_clk),
        .sys_reset      (sys_reset),
        .crop_valid_i   (crop_valid_w),
        .crop_sof_i     (crop_sof_w),
        .crop_data_i    (crop_data_w),
        .crop_odd_row_i (crop_odd_row_w),
        .crop_odd_col_i (crop_odd_col_w),
        .bin_valid_o    (bin_valid_w),
        .bin_sof_o      (bin_sof_w),
        .bin_data_o     (bin_data_w)
    );

    stream_fifo fifo0 (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .wr_en_i    (bin_valid_w),
        .wr_sof_i   (bin_sof_w),
        .wr_data_i  (bin_data_w),
        .rd_en_i    (fifo_rd_en_w),
        .rd_valid_o (fifo_valid_w),
        .rd_sof_o   (fifo_sof_w),
        .rd_data_o  (fifo_data_w)
    );

    // header plus pixels out to the host
    frame_packer packer0 (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .rd_valid_i (fifo_valid_w),
        .rd_sof_i   (fifo_sof_w),
        .rd_data_i  (fifo_data_w),
        .tx_stall_i (tx_stall_i),
        .rd_en_o    (fifo_rd_en_w),
        .tx_valid_o (tx_valid_o),
        .tx_data_o  (tx_data_o)
    );

endmodule

// File: sim/tb_preview.sv
module tb_preview;

    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////
    // test constants
    ////////////////////

    localparam int NUM_TESTS   = 11;
    // corner col, corner row, stall mode, 16 pixels
    localparam int LINE_WORDS  = 19;
    localparam int HDR_BYTES   = 8;
    localparam int FRAME_BYTES = 24;
    localparam int FRAME_W     = 16;
    localparam int FRAME_H     = 12;
    localparam int CYCLE_LIMIT = 400 * NUM_TESTS + 200;

    localparam logic [63:0] HEADER     = "BIVFRAME";
    localparam logic [15:0] ADDR_COL   = 16'h0000;
    localparam logic [15:0] ADDR_ROW   = 16'h0001;
    localparam logic [15:0] ADDR_BOGUS = 16'h00a5;

    logic       core_clk;
    logic       sys_reset;
    logic       pix_valid_i;
    logic       pix_sof_i;
    logic [7:0] pix_data_i;
    logic       host_valid_i;
    logic [7:0] host_data_i;
    logic       tx_stall_i;
    logic       tx_valid_o;
    logic [7:0] tx_data_o;

    logic [7:0]  vec_mem [0:NUM_TESTS*LINE_WORDS-1];
    logic [31:0] lcg_state;
    int          errors;
    int          rx_count;
    int          cycles;

    preview_top dut0 (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .pix_valid_i  (pix_valid_i),
        .pix_sof_i    (pix_sof_i),
        .pix_data_i   (pix_data_i),
        .host_valid_i (host_valid_i),
        .host_data_i  (host_data_i),
        .tx_stall_i   (tx_stall_i),
        .tx_valid_o   (tx_valid_o),
        .tx_data_o    (tx_data_o)
    );

    initial begin
        core_clk = 1'b0;
        forever #20 core_clk = ~core_clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // header byte or binned pixel for stream position index
    function automatic logic [7:0] expected_byte(input int index);
        int frame;
        int pos;
        frame = index / FRAME_BYTES;
        pos   = index % FRAME_BYTES;
        if (pos < HDR_BYTES) begin
            return HEADER[63 - 8*pos -: 8];
        end
        return vec_mem[frame*LINE_WORDS + 3 + pos - HDR_BYTES];
    endfunction

    task automatic send_command(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] cmd;
        int          k;
        cmd = {addr, data};
        for (k = 0; k < 6; k++) begin
            @(posedge core_clk);
            #2;
            host_valid_i = 1'b1;
            host_data_i  = cmd[47 - 8*k -: 8];
        end
        @(posedge core_clk);
        #2;
        host_valid_i = 1'b0;
    endtask

    // leaves valid high so the next frame can follow directly
    task automatic send_frame();
        int r;
        int c;
        for (r = 0; r < FRAME_H; r++) begin
            for (c = 0; c < FRAME_W; c++) begin
                @(posedge core_clk);
                #2;
                pix_valid_i = 1'b1;
                pix_sof_i   = (r == 0) && (c == 0);
                pix_data_i  = 8'(r * FRAME_W + c);
            end
        end
    endtask

    task automatic stop_pixels();
        @(posedge core_clk);
        #2;
        pix_valid_i = 1'b0;
        pix_sof_i   = 1'b0;
    endtask

    task automatic wait_bytes(input int count);
        while (rx_count < count) begin
            @(posedge core_clk);
        end
    endtask

    ////////////////////
    // host side
    ////////////////////

    // stall mode follows the frame currently on the output
    initial begin
        lcg_state  = 32'he453;
        tx_stall_i = 1'b0;
        forever begin
            @(posedge core_clk);
            #2;
            lcg_state = lcg_next(lcg_state);
            if (rx_count < NUM_TESTS * FRAME_BYTES &&
                vec_mem[(rx_count / FRAME_BYTES) * LINE_WORDS + 2] == 8'd1) begin
                tx_stall_i = lcg_state[16];
            end else begin
                tx_stall_i = 1'b0;
            end
        end
    end

    // transfers happen on the rising edge, so sample mid cycle
    initial begin
        rx_count = 0;
        forever begin
            @(negedge core_clk);
            if (tx_stall_i) begin
                check_value("tx_valid_o", 32'd0, 32'(tx_valid_o));
            end
            if (tx_valid_o === 1'b1) begin
                if (rx_count >= NUM_TESTS * FRAME_BYTES) begin
                    errors++;
                    $display("error at %0t ns: extra byte 0x%0h after the last frame",
                             $time, tx_data_o);
                end else begin
                    check_value($sformatf("tx_data_o[byte %0d]", rx_count),
                                32'(expected_byte(rx_count)), 32'(tx_data_o));
                end
                rx_count++;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge core_clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d bytes received",
                 cycles, rx_count, NUM_TESTS * FRAME_BYTES);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        logic [7:0] cur_col;
        logic [7:0] cur_row;
        logic [7:0] col;
        logic [7:0] row;
        int         i;
        errors       = 0;
        sys_reset    = 1'b1;
        pix_valid_i  = 1'b0;
        pix_sof_i    = 1'b0;
        pix_data_i   = 8'd0;
        host_valid_i = 1'b0;
        host_data_i  = 8'd0;
        // corner after reset
        cur_col = 8'd4;
        cur_row = 8'd2;
        $readmemh("sim/preview_vectors.txt", vec_mem);
        repeat (10) @(posedge core_clk);
        #2;
        sys_reset = 1'b0;
        check_value("tx_valid_o", 32'd0, 32'(tx_valid_o));

        if ($isunknown(vec_mem[NUM_TESTS*LINE_WORDS-1])) begin
            errors++;
            $display("error: vector file sim/preview_vectors.txt is missing or too short");
        end else begin
            for (i = 0; i < NUM_TESTS; i++) begin
                col = vec_mem[i*LINE_WORDS];
                row = vec_mem[i*LINE_WORDS + 1];
                // same corner as before means the frame follows back to back
                if (i > 0 && (col != cur_col || row != cur_row)) begin
                    stop_pixels();
                    wait_bytes(i * FRAME_BYTES);
                    send_command(ADDR_COL, {24'd0, col});
                    send_command(ADDR_ROW, {24'd0, row});
                    // must leave both corners alone
                    send_command(ADDR_BOGUS, 32'h0000_0001);
                    cur_col = col;
                    cur_row = row;
                end
                send_frame();
            end
            stop_pixels();
            wait_bytes(NUM_TESTS * FRAME_BYTES);
            // room for any stray bytes to show up
            repeat (40) @(posedge core_clk);
        end

        $display("errors: %0d, bytes received: %0d of %0d",
                 errors, rx_count, NUM_TESTS * FRAME_BYTES);
        if (errors == 0 && rx_count == NUM_TESTS * FRAME_BYTES) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim/preview_vectors.txt
// columns: corner col, corner row, stall mode (0 none, 1 random),
// then the 16 expected binned pixels in raster order, all hex
04 02 00 2c 2e 30 32 4c 4e 50 52 6c 6e 70 72 8c 8e 90 92
00 00 00 08 0a 0c 0e 28 2a 2c 2e 48 4a 4c 4e 68 6a 6c 6e
08 04 01 50 52 54 56 70 72 74 76 90 92 94 96 b0 b2 b4 b6
08 04 01 50 52 54 56 70 72 74 76 90 92 94 96 b0 b2 b4 b6
03 01 01 1b 1d 1f 21 3b 3d 3f 41 5b 5d 5f 61 7b 7d 7f 81
06 03 00 3e 40 42 44 5e 60 62 64 7e 80 82 84 9e a0 a2 a4
06 03 01 3e 40 42 44 5e 60 62 64 7e 80 82 84 9e a0 a2 a4
02 04 01 4a 4c 4e 50 6a 6c 6e 70 8a 8c 8e 90 aa ac ae b0
07 00 00 0f 11 13 15 2f 31 33 35 4f 51 53 55 6f 71 73 75
05 02 01 2d 2f 31 33 4d 4f 51 53 6d 6f 71 73 8d 8f 91 93
05 02 01 2d 2f 31 33 4d 4f 51 53 6d 6f 71 73 8d 8f 91 93

// File: compile.f
rtl/video_pkg.sv
rtl/host_pkg.sv
rtl/roi_crop.sv
rtl/pixel_binner.sv
rtl/stream_fifo.sv
rtl/frame_packer.sv
rtl/roi_command_regs.sv
rtl/preview_top.sv
sim/tb_preview.sv

// File: Makefile
# Verilator flow for the preview pipeline

VERILATOR ?= verilator
TOP       ?= tb_preview
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -j 0
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
